// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_cpu
RTL_TOP    ?= cpu
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
PASS_MSG   ?= ** PASS **
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
+incdir+.
cpu_pkg.sv
fwd_if.sv
pipe_reg.sv
ram_sync.sv
reg_file.sv
instr_decode.sv
alu.sv
hazard_unit.sv
cpu.sv
tb_cpu.sv

// ==== alu.sv ====
`default_nettype none

module alu import cpu_pkg::*; (
  input  logic [15:0] a,
  input  logic [15:0] b,
  input  opcode_e     op,
  input  logic [2:0]  cond,
  input  logic [2:0]  flags,
  output logic [15:0] y,
  output logic        z,
  output logic        v,
  output logic        n,
  output logic        taken
);

  logic [16:0] sum;
  logic        ovf;
  logic [15:0] sat;
  logic [31:0] rot;

  // one extra sign bit exposes signed overflow
  assign sum = (op == OP_SUB) ? {a[15], a} - {b[15], b} : {a[15], a} + {b[15], b};
  assign ovf = sum[16] ^ sum[15];
  // clamp toward the true sign
  assign sat = !ovf ? sum[15:0] : (sum[16] ? 16'h8000 : 16'h7fff);
  assign rot = {a, a} >> b[3:0];

  always_comb begin
    y = a;
    v = 1'b0;
    case (op)
      OP_ADD, OP_SUB: begin
        y = sat;
        v = ovf;
      end
      OP_XOR:        y = a ^ b;
      OP_SLL:        y = a << b[3:0];
      OP_SRA:        y = $signed(a) >>> b[3:0];
      OP_ROR:        y = rot[15:0];
      // effective address
      OP_LW, OP_SW:  y = a + b;
      OP_LLB:        y = {a[15:8], b[7:0]};
      OP_LHB:        y = {b[7:0], a[7:0]};
      default:       y = a;
    endcase
  end

  assign z = (y == 16'h0000);
  assign n = y[15];

  // branch test on the stored flags
  always_comb begin
    case (cond)
      3'b000:  taken = !flags[FLAG_Z];
      3'b001:  taken = flags[FLAG_Z];
      3'b010:  taken = !flags[FLAG_Z] && !flags[FLAG_N];
      3'b011:  taken = flags[FLAG_N];
      3'b100:  taken = flags[FLAG_Z] || !flags[FLAG_N];
      3'b101:  taken = flags[FLAG_N] || flags[FLAG_Z];
      3'b110:  taken = flags[FLAG_V];
      default: taken = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== cpu.sv ====
`default_nettype none

`include "cpu_macros.svh"

module cpu import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 run,
  input  logic                 prog_we,
  input  logic [`CPU_XLEN-1:0] prog_addr,
  input  logic [`CPU_XLEN-1:0] prog_data,
  output logic [`CPU_XLEN-1:0] pc,
  output logic                 hlt,
  output logic                 retire_valid,
  output logic [3:0]           retire_rd,
  output logic [`CPU_XLEN-1:0] retire_data
);

  localparam int IAW = $clog2(`CPU_IMEM_WORDS);
  localparam int DAW = $clog2(`CPU_DMEM_WORDS);

  fwd_if fwd ();

  if_id_t  fd_d, fd_q;
  id_ex_t  de_d, de_q;
  ex_mem_t em_d, em_q;
  mem_wb_t mw_d, mw_q;

  logic [`CPU_XLEN-1:0] pc_next, imem_rdata, dmem_rdata, id_pc_next, wb_data;
  logic [`CPU_XLEN-1:0] op_a, op_b, alu_b, alu_y;
  logic [IAW-1:0]       imem_addr;
  logic [3:0]           dec_rs, dec_rt, dec_rd;
  logic [`CPU_XLEN-1:0] dec_imm, rs_data, rt_data;
  ctrl_t                dec_ctrl;
  logic [2:0]           flags;
  logic                 alu_z, alu_v, alu_n, alu_taken;
  logic                 imem_load, imem_fresh, halt_q;
  logic                 fetch_go, fetch_hlt, taken, stall;

  // fetch
  // program load owns the RAM port while run is low
  assign imem_load = !run && prog_we;
  assign imem_addr = imem_load ? prog_addr[IAW-1:0] : pc_next[IAW:1];

  // RAM is addressed with pc_next so its output lines up with pc
  ram_sync #(.depth(`CPU_IMEM_WORDS)) u_imem (
    .clk(clk), .we(imem_load), .addr(imem_addr), .wdata(prog_data), .rdata(imem_rdata)
  );

  // rdata is stale right after a load write
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      imem_fresh <= 1'b0;
    end else begin
      imem_fresh <= !imem_load;
    end
  end

  assign fetch_go  = run && !halt_q && imem_fresh;
  assign fetch_hlt = fetch_go && (opcode_e'(imem_rdata[15:12]) == OP_HLT);

  // taken branch first, then hold on stall, no fetch or HLT
  assign pc_next = taken                             ? de_q.imm  :
                   (fetch_go && !stall && !fetch_hlt) ? pc + 16'd2 : pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

  assign fd_d.valid = fetch_go;
  assign fd_d.pc    = pc;
  assign fd_d.instr = imem_rdata;

  pipe_reg #(.payload_t(if_id_t)) u_if_id (
    .clk(clk), .arst_n(arst_n), .hold(stall), .flush(taken), .d(fd_d), .q(fd_q)
  );

  // decode
  assign id_pc_next = fd_q.pc + 16'd2;

  instr_decode u_dec (
    .instr(fd_q.instr), .pc(fd_q.pc), .pc_next(id_pc_next),
    .rs(dec_rs), .rt(dec_rt), .rd(dec_rd), .imm(dec_imm), .ctrl(dec_ctrl)
  );

  reg_file u_rf (
    .clk(clk), .arst_n(arst_n),
    .rs(dec_rs), .rt(dec_rt), .rs_data(rs_data), .rt_data(rt_data),
    .we(mw_q.ctrl.reg_write), .rd(mw_q.rd), .wdata(wb_data),
    .z_en(de_q.ctrl.z_en), .v_en(de_q.ctrl.v_en), .n_en(de_q.ctrl.n_en),
    .z_in(alu_z), .v_in(alu_v), .n_in(alu_n), .flags(flags)
  );

  // invalid fetch slots decode to a bubble
  assign de_d.ctrl    = fd_q.valid ? dec_ctrl : '0;
  assign de_d.rs      = dec_rs;
  assign de_d.rt      = dec_rt;
  assign de_d.rd      = dec_rd;
  assign de_d.rs_data = rs_data;
  assign de_d.rt_data = rt_data;
  assign de_d.imm     = dec_imm;
  assign de_d.pc      = fd_q.pc;

  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
    .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(taken || stall), .d(de_d), .q(de_q)
  );

  // hazard detection
  assign fwd.id_rs         = dec_rs;
  assign fwd.id_rt         = dec_rt;
  assign fwd.ex_rs         = de_q.rs;
  assign fwd.ex_rt         = de_q.rt;
  assign fwd.ex_rd         = de_q.rd;
  assign fwd.ex_mem_read   = de_q.ctrl.mem_read;
  assign fwd.mem_rd        = em_q.rd;
  assign fwd.mem_reg_write = em_q.ctrl.reg_write;
  assign fwd.wb_rd         = mw_q.rd;
  assign fwd.wb_reg_write  = mw_q.ctrl.reg_write;
  assign stall             = fwd.stall;

  hazard_unit u_hz (.fwd(fwd.hazard));

  // execute operand muxes
  always_comb begin
    case (fwd.fwd_a)
      FROM_MEM: op_a = em_q.y;
      FROM_WB:  op_a = wb_data;
      default:  op_a = de_q.rs_data;
    endcase
    case (fwd.fwd_b)
      FROM_MEM: op_b = em_q.y;
      FROM_WB:  op_b = wb_data;
      default:  op_b = de_q.rt_data;
    endcase
  end

  assign alu_b = de_q.ctrl.use_imm ? de_q.imm : op_b;

  alu u_alu (
    .a(op_a), .b(alu_b), .op(de_q.ctrl.op), .cond(de_q.ctrl.cond), .flags(flags),
    .y(alu_y), .z(alu_z), .v(alu_v), .n(alu_n), .taken(alu_taken)
  );

  assign taken = de_q.ctrl.is_branch && alu_taken;

  assign em_d.ctrl    = de_q.ctrl;
  assign em_d.rd      = de_q.rd;
  // PCS carries its return address in imm
  assign em_d.y       = de_q.ctrl.is_pcs ? de_q.imm : alu_y;
  assign em_d.st_data = op_b;

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0), .d(em_d), .q(em_q)
  );

  // memory
  ram_sync #(.depth(`CPU_DMEM_WORDS)) u_dmem (
    .clk(clk), .we(em_q.ctrl.mem_write), .addr(em_q.y[DAW:1]),
    .wdata(em_q.st_data), .rdata(dmem_rdata)
  );

  assign mw_d.ctrl = em_q.ctrl;
  assign mw_d.rd   = em_q.rd;
  assign mw_d.y    = em_q.y;

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk(clk), .arst_n(arst_n), .hold(1'b0), .flush(1'b0), .d(mw_d), .q(mw_q)
  );

  // writeback
  assign wb_data = mw_q.ctrl.to_mem_data ? dmem_rdata : mw_q.y;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_q <= 1'b0;
    end else if (mw_q.ctrl.is_hlt) begin
      halt_q <= 1'b1;
    end
  end

  assign hlt          = halt_q || mw_q.ctrl.is_hlt;
  assign retire_valid = mw_q.ctrl.reg_write && (mw_q.rd != 4'd0);
  assign retire_rd    = mw_q.rd;
  assign retire_data  = wb_data;

endmodule

`default_nettype wire

// ==== cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// data and instruction word width
`define CPU_XLEN 16

// architectural registers, r0 reads as zero
`define CPU_NREGS 16

// memory depths in 16-bit words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

`endif

// ==== cpu_pkg.sv ====
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

  // opcode lives in instr[15:12]
  // codes not listed here run as no-ops
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,
    OP_SUB = 4'b0001,
    OP_XOR = 4'b0010,
    OP_SLL = 4'b0100,
    OP_SRA = 4'b0101,
    OP_ROR = 4'b0110,
    OP_LW  = 4'b1000,
    OP_SW  = 4'b1001,
    OP_LLB = 4'b1010,
    OP_LHB = 4'b1011,
    OP_B   = 4'b1100,
    OP_PCS = 4'b1110,
    OP_HLT = 4'b1111
  } opcode_e;

  // bit positions inside the V N Z flag register
  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_V = 2;

  // operand source for execute
  typedef enum logic [1:0] {
    NONE     = 2'd0,
    FROM_MEM = 2'd1,
    FROM_WB  = 2'd2
  } fwd_sel_e;

  // all-zero value is a bubble
  typedef struct packed {
    opcode_e    op;
    logic [2:0] cond;
    logic       reg_write;
    logic       mem_read;
    logic       mem_write;
    // writeback takes the load data
    logic       to_mem_data;
    logic       use_imm;
    logic       is_branch;
    logic       is_pcs;
    logic       is_hlt;
    logic       z_en;
    logic       v_en;
    logic       n_en;
  } ctrl_t;

  typedef struct packed {
    logic                 valid;
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t                ctrl;
    logic [3:0]           rs;
    logic [3:0]           rt;
    logic [3:0]           rd;
    logic [`CPU_XLEN-1:0] rs_data;
    logic [`CPU_XLEN-1:0] rt_data;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] pc;
  } id_ex_t;

  typedef struct packed {
    ctrl_t                ctrl;
    logic [3:0]           rd;
    logic [`CPU_XLEN-1:0] y;
    logic [`CPU_XLEN-1:0] st_data;
  } ex_mem_t;

  // load data is not carried here
  // it comes straight off the data RAM in writeback
  typedef struct packed {
    ctrl_t                ctrl;
    logic [3:0]           rd;
    logic [`CPU_XLEN-1:0] y;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== fwd_if.sv ====
`default_nettype none

interface fwd_if import cpu_pkg::*; ();

  // source registers of the instruction in decode
  logic [3:0] id_rs;
  logic [3:0] id_rt;
  // instruction in execute
  logic [3:0] ex_rs;
  logic [3:0] ex_rt;
  logic [3:0] ex_rd;
  logic       ex_mem_read;
  // producers further down the pipe
  logic [3:0] mem_rd;
  logic       mem_reg_write;
  logic [3:0] wb_rd;
  logic       wb_reg_write;
  // decisions back to the core
  fwd_sel_e   fwd_a;
  fwd_sel_e   fwd_b;
  logic       stall;

  modport core (
    output id_rs, id_rt, ex_rs, ex_rt, ex_rd, ex_mem_read,
    output mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    input  fwd_a, fwd_b, stall
  );

  modport hazard (
    input  id_rs, id_rt, ex_rs, ex_rt, ex_rd, ex_mem_read,
    input  mem_rd, mem_reg_write, wb_rd, wb_reg_write,
    output fwd_a, fwd_b, stall
  );

endinterface

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none

module hazard_unit import cpu_pkg::*; (
  fwd_if.hazard fwd
);

  // newest producer wins
  // r0 never forwards
  function automatic fwd_sel_e pick(
    input logic [3:0] src,
    input logic [3:0] m_rd,
    input logic       m_we,
    input logic [3:0] w_rd,
    input logic       w_we
  );
    if (m_we && m_rd != 4'd0 && m_rd == src) begin
      return FROM_MEM;
    end
    if (w_we && w_rd != 4'd0 && w_rd == src) begin
      return FROM_WB;
    end
    return NONE;
  endfunction

  assign fwd.fwd_a = pick(fwd.ex_rs, fwd.mem_rd, fwd.mem_reg_write,
                          fwd.wb_rd, fwd.wb_reg_write);
  assign fwd.fwd_b = pick(fwd.ex_rt, fwd.mem_rd, fwd.mem_reg_write,
                          fwd.wb_rd, fwd.wb_reg_write);

  // load data is only ready in writeback
  // a consumer right behind the load waits one cycle
  assign fwd.stall = fwd.ex_mem_read && fwd.ex_rd != 4'd0 &&
                     (fwd.ex_rd == fwd.id_rs || fwd.ex_rd == fwd.id_rt);

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
`default_nettype none

module instr_decode import cpu_pkg::*; (
  input  logic [15:0] instr,
  input  logic [15:0] pc,
  input  logic [15:0] pc_next,
  output logic [3:0]  rs,
  output logic [3:0]  rt,
  output logic [3:0]  rd,
  output logic [15:0] imm,
  output ctrl_t       ctrl
);

  opcode_e     op;
  logic [15:0] mem_off;
  logic [15:0] br_off;

  assign op = opcode_e'(instr[15:12]);

  // word offsets become byte offsets
  assign mem_off = {{11{instr[3]}}, instr[3:0], 1'b0};
  assign br_off  = {{6{instr[8]}}, instr[8:0], 1'b0};

  always_comb begin
    rd        = instr[11:8];
    rs        = instr[7:4];
    rt        = instr[3:0];
    imm       = '0;
    ctrl      = '0;
    ctrl.op   = op;
    ctrl.cond = instr[11:9];
    case (op)
      OP_ADD, OP_SUB: begin
        ctrl.reg_write = 1'b1;
        ctrl.z_en      = 1'b1;
        ctrl.v_en      = 1'b1;
        ctrl.n_en      = 1'b1;
      end
      OP_XOR: begin
        ctrl.reg_write = 1'b1;
        ctrl.z_en      = 1'b1;
      end
      OP_SLL, OP_SRA, OP_ROR: begin
        // 4-bit shift amount sits where rt would
        ctrl.reg_write = 1'b1;
        ctrl.z_en      = 1'b1;
        ctrl.use_imm   = 1'b1;
        imm            = {12'h000, instr[3:0]};
      end
      OP_LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.to_mem_data = 1'b1;
        ctrl.use_imm     = 1'b1;
        imm              = mem_off;
      end
      OP_SW: begin
        // store data register is in the rd field
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        rt             = instr[11:8];
        imm            = mem_off;
      end
      OP_LLB, OP_LHB: begin
        // read-modify-write of rd
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        rs             = instr[11:8];
        imm            = {8'h00, instr[7:0]};
      end
      OP_B: begin
        // target relative to the word after the branch
        ctrl.is_branch = 1'b1;
        imm            = pc + 16'd2 + br_off;
      end
      OP_PCS: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_pcs    = 1'b1;
        imm            = pc_next;
      end
      OP_HLT: begin
        ctrl.is_hlt = 1'b1;
      end
      // unknown opcodes keep ctrl clear
      default: begin
        ctrl.op = op;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== pipe_reg.sv ====
`default_nettype none

module pipe_reg import cpu_pkg::*; #(
  parameter type payload_t = if_id_t
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // reset and flush both leave the all-zero bubble
  // flush wins over hold
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

// ==== ram_sync.sv ====
`default_nettype none

`include "cpu_macros.svh"

module ram_sync #(
  parameter int depth = 256
) (
  input  logic                       clk,
  input  logic                       we,
  input  logic [$clog2(depth)-1:0]   addr,
  input  logic [`CPU_XLEN-1:0]       wdata,
  output logic [`CPU_XLEN-1:0]       rdata
);

  logic [`CPU_XLEN-1:0] mem [depth];

  // one access per cycle
  // a write also shows up on rdata the next cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
      rdata     <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

`include "cpu_macros.svh"

module reg_file import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [3:0]           rs,
  input  logic [3:0]           rt,
  output logic [`CPU_XLEN-1:0] rs_data,
  output logic [`CPU_XLEN-1:0] rt_data,
  input  logic                 we,
  input  logic [3:0]           rd,
  input  logic [`CPU_XLEN-1:0] wdata,
  input  logic                 z_en,
  input  logic                 v_en,
  input  logic                 n_en,
  input  logic                 z_in,
  input  logic                 v_in,
  input  logic                 n_in,
  output logic [2:0]           flags
);

  logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

  // writes to r0 are dropped
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 4'd0) begin
      regs[rd] <= wdata;
    end
  end

  // same-cycle write shows through to decode
  assign rs_data = (rs == 4'd0)          ? '0    :
                   (we && rd == rs)      ? wdata : regs[rs];
  assign rt_data = (rt == 4'd0)          ? '0    :
                   (we && rd == rt)      ? wdata : regs[rt];

  // flags are written from execute
  // each bit moves only under its own enable
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= 3'b000;
    end else begin
      if (z_en) flags[FLAG_Z] <= z_in;
      if (v_en) flags[FLAG_V] <= v_in;
      if (n_en) flags[FLAG_N] <= n_in;
    end
  end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`default_nettype none

`include "cpu_macros.svh"

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int  CLK_HALF     = 2;
  localparam real DRIVE_DLY    = 0.5;
  localparam int  RESET_CYCLES = 5;
  localparam int  PROG_LEN     = 50;
  localparam int  LOAD_CYCLES  = 1;
  localparam int  DRAIN_CYCLES = 8;
  localparam int  TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * 20 + PROG_LEN * LOAD_CYCLES;
  // byte address of the HLT word
  localparam logic [15:0] HLT_PC  = 16'h005e;
  // run is randomly dropped while pc is in this window
  localparam logic [15:0] GATE_LO = 16'h0022;
  localparam logic [15:0] GATE_HI = 16'h005e;

  logic                 clk;
  logic                 arst_n;
  logic                 run;
  logic                 prog_we;
  logic [`CPU_XLEN-1:0] prog_addr;
  logic [`CPU_XLEN-1:0] prog_data;
  logic [`CPU_XLEN-1:0] pc;
  logic                 hlt;
  logic                 retire_valid;
  logic [3:0]           retire_rd;
  logic [`CPU_XLEN-1:0] retire_data;

  logic [15:0] prog_word [PROG_LEN];
  int          nrows;
  // expected writes in retire order
  logic [3:0]  exp_rd [$];
  logic [15:0] exp_data [$];
  int          exp_idx;
  int          rows_at_halt;
  logic [15:0] lfsr;
  logic        in_gate;

  cpu UUT (
    .clk(clk), .arst_n(arst_n), .run(run),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .pc(pc), .hlt(hlt),
    .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAIL t=%0.1f ns: %s got 0x%04h expected 0x%04h",
               $realtime, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  // one program word and, when it writes, the result it must retire
  task automatic add_row(input logic [15:0] word, input logic wr,
                         input logic [3:0] rd, input logic [15:0] val);
    prog_word[nrows] = word;
    nrows++;
    if (wr) begin
      exp_rd.push_back(rd);
      exp_data.push_back(val);
    end
  endtask

  task automatic build_table();
    nrows = 0;
    // constants from llb and lhb, back-to-back on the same register
    add_row(16'ha134, 1'b1, 4'd1,  16'h0034);
    add_row(16'hb112, 1'b1, 4'd1,  16'h1234);
    add_row(16'ha2ff, 1'b1, 4'd2,  16'h00ff);
    add_row(16'hb27f, 1'b1, 4'd2,  16'h7fff);
    // positive saturation
    add_row(16'h0312, 1'b1, 4'd3,  16'h7fff);
    add_row(16'ha400, 1'b1, 4'd4,  16'h0000);
    add_row(16'hb480, 1'b1, 4'd4,  16'h8000);
    // 0x8000 - 0x1234 saturates negative
    add_row(16'h1541, 1'b1, 4'd5,  16'h8000);
    add_row(16'h2612, 1'b1, 4'd6,  16'h6dcb);
    // sll 4, sra 3, ror 4
    add_row(16'h4714, 1'b1, 4'd7,  16'h2340);
    add_row(16'h5843, 1'b1, 4'd8,  16'hf000);
    add_row(16'h6914, 1'b1, 4'd9,  16'h4123);
    // chained sums through both forward paths
    add_row(16'h0a11, 1'b1, 4'd10, 16'h2468);
    add_row(16'h1ba1, 1'b1, 4'd11, 16'h1234);
    add_row(16'h0cab, 1'b1, 4'd12, 16'h369c);
    // write to r0 gives no pulse, then r0 reads as zero
    add_row(16'h0012, 1'b0, 4'd0,  16'h0000);
    add_row(16'h0d01, 1'b1, 4'd13, 16'h1234);
    // memory section, base r14 = 0x40
    add_row(16'hae40, 1'b1, 4'd14, 16'h0040);
    add_row(16'h91e0, 1'b0, 4'd0,  16'h0000);
    add_row(16'h92e1, 1'b0, 4'd0,  16'h0000);
    add_row(16'h8fe0, 1'b1, 4'd15, 16'h1234);
    add_row(16'h85e1, 1'b1, 4'd5,  16'h7fff);
    // load-use on r5
    add_row(16'h165f, 1'b1, 4'd6,  16'h6dcb);
    // store and load at offset -4
    add_row(16'h96ee, 1'b0, 4'd0,  16'h0000);
    add_row(16'h88ee, 1'b1, 4'd8,  16'h6dcb);
    add_row(16'h2981, 1'b1, 4'd9,  16'h7fff);
    // zero result, then beq over two words
    add_row(16'h1a11, 1'b1, 4'd10, 16'h0000);
    add_row(16'hc202, 1'b0, 4'd0,  16'h0000);
    add_row(16'habaa, 1'b0, 4'd0,  16'h0000);
    add_row(16'hacbb, 1'b0, 4'd0,  16'h0000);
    // bne falls through while Z is set
    add_row(16'hc001, 1'b0, 4'd0,  16'h0000);
    add_row(16'h0b12, 1'b1, 4'd11, 16'h7fff);
    // overflow branch skips one word
    add_row(16'hcc01, 1'b0, 4'd0,  16'h0000);
    add_row(16'haccc, 1'b0, 4'd0,  16'h0000);
    // pcs at 0x44
    add_row(16'hec00, 1'b1, 4'd12, 16'h0046);
    add_row(16'h1d41, 1'b1, 4'd13, 16'h8000);
    // gt not taken, lt taken
    add_row(16'hc402, 1'b0, 4'd0,  16'h0000);
    add_row(16'hc602, 1'b0, 4'd0,  16'h0000);
    add_row(16'ha100, 1'b0, 4'd0,  16'h0000);
    add_row(16'ha200, 1'b0, 4'd0,  16'h0000);
    add_row(16'h03cc, 1'b1, 4'd3,  16'h008c);
    // ge taken, then always over a hlt in the shadow
    add_row(16'hc801, 1'b0, 4'd0,  16'h0000);
    add_row(16'ha411, 1'b0, 4'd0,  16'h0000);
    add_row(16'hce02, 1'b0, 4'd0,  16'h0000);
    add_row(16'ha522, 1'b0, 4'd0,  16'h0000);
    add_row(16'hf000, 1'b0, 4'd0,  16'h0000);
    add_row(16'h073d, 1'b1, 4'd7,  16'h808c);
    add_row(16'hf000, 1'b0, 4'd0,  16'h0000);
    // past the halt, never fetched
    add_row(16'ha855, 1'b0, 4'd0,  16'h0000);
    add_row(16'h0911, 1'b0, 4'd0,  16'h0000);
  endtask

  // trace monitor, samples mid-cycle
  always @(negedge clk) begin
    if (arst_n && retire_valid) begin
      if (exp_idx >= exp_rd.size()) begin
        $display("unexpected retire of r%0d = 0x%04h at %0.1f ns, no result was left to retire",
                 retire_rd, retire_data, $realtime);
        $display("** FAIL **");
        $fatal(1, "extra retire");
      end else begin
        check_equal({12'h000, retire_rd}, {12'h000, exp_rd[exp_idx]},
                    $sformatf("retire %0d rd", exp_idx));
        check_equal(retire_data, exp_data[exp_idx], $sformatf("retire %0d data", exp_idx));
        exp_idx++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout, the core did not halt within %0d cycles", TIMEOUT_CYCLES);
    $display("** FAIL **");
    $fatal(1, "watchdog");
  end

  initial begin
    arst_n    = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    exp_idx   = 0;
    lfsr      = 16'd55;
    in_gate   = 1'b0;
    build_table();

    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DLY);
    arst_n = 1'b1;
    check_equal({15'd0, hlt}, 16'd0, "hlt after reset");
    check_equal({15'd0, retire_valid}, 16'd0, "retire_valid after reset");
    check_equal(pc, 16'h0000, "pc after reset");

    // program load with run low
    for (int i = 0; i < PROG_LEN; i++) begin
      @(posedge clk);
      #(DRIVE_DLY);
      prog_we   = 1'b1;
      prog_addr = 16'(i);
      prog_data = prog_word[i];
    end
    @(posedge clk);
    #(DRIVE_DLY);
    prog_we = 1'b0;

    // one lfsr step per cycle, its low bit gates run inside the window
    while (!hlt) begin
      lfsr    = lfsr_next(lfsr);
      in_gate = (pc >= GATE_LO) && (pc < GATE_HI);
      run     = in_gate ? lfsr[0] : 1'b1;
      @(posedge clk);
      #(DRIVE_DLY);
    end
    rows_at_halt = exp_idx;

    // nothing may retire after the halt and pc must stay put
    run = 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(posedge clk);
      #(DRIVE_DLY);
      check_equal(pc, HLT_PC, "pc after halt");
      check_equal({15'd0, hlt}, 16'd1, "hlt held");
    end

    if (rows_at_halt != exp_rd.size()) begin
      $display("halt reached with %0d of %0d expected results retired",
               rows_at_halt, exp_rd.size());
      $display("** FAIL **");
      $fatal(1, "early halt");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

`default_nettype wire
